//--- common/neoB1Pkg.sv
`default_nettype none

// Shared types for the pixel output stage
package neoB1Pkg;

	localparam int lineWidth = 256;	// Pixel slots per line
	localparam int paWidth = 12;	// Palette RAM address bits

	// Sprite fields carried on the P bus
	typedef struct packed
	{
		logic [7:0] sprPal;	// Top byte
		logic [7:0] sprX;	// Middle byte
		logic [7:0] unused;
	} pBusSpr_t;

	// Fix fields carried on the P bus
	typedef struct packed
	{
		logic [3:0] unusedHi;
		logic [3:0] fixPal;	// Bits 19:16
		logic [15:0] unusedLo;
	} pBusFix_t;

	// Same 24-bit word, read as sprite or as fix data
	typedef union packed
	{
		pBusSpr_t sprView;
		pBusFix_t fixView;
	} pBusWord_u;

	// Line buffer slot and sprite pixel
	typedef struct packed
	{
		logic [7:0] pal;
		logic [3:0] color;	// 0 is transparent
	} sprPix_t;

	// Fix layer pixel
	typedef struct packed
	{
		logic [3:0] pal;
		logic [3:0] color;	// Non-zero means opaque
	} fixPix_t;

	// Palette RAM address word
	typedef struct packed
	{
		logic [7:0] pal;
		logic [3:0] color;
	} paWord_t;

endpackage

`default_nettype wire

//--- hdl/fixPixelUnit.sv
`timescale 1ns/10ps
`default_nettype none

// Fix layer pixel path
// Each tile byte holds two 4-bit pixels, low nibble first
module fixPixelUnit
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire neoB1Pkg::pBusWord_u pBus,
	input wire logic fixPalLd,
	input wire logic fixLd,
	input wire logic [7:0] fixd,
	input wire logic lineStart,
	output neoB1Pkg::fixPix_t fixPix
);

	import neoB1Pkg::*;

	logic [3:0] fixPal;	// Fix palette latch
	logic [7:0] fixByte;	// Tile byte latch, two pixels
	logic phase;	// 0 even pixel, 1 odd pixel
	logic [3:0] fixColor;

	// Latches
	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			fixPal <= '0;
			fixByte <= '0;
		end
		else
		begin
			if (fixPalLd)
				fixPal <= pBus.fixView.fixPal;
			if (fixLd)
				fixByte <= fixd;
		end
	end

	// Even/odd nibble select
	assign fixColor = phase ? fixByte[7:4] : fixByte[3:0];

	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			phase <= 1'b0;
			fixPix <= '0;
		end
		else
		begin
			// Line start lines up pixel 0 with the even phase
			if (lineStart)
				phase <= 1'b0;
			else
				phase <= ~phase;

			// One cycle behind its phase, same as the line buffer read
			fixPix <= '{pal: fixPal, color: fixColor};
		end
	end

endmodule

`default_nettype wire

//--- hdl/neoB1Top.sv
`timescale 1ns/10ps
`default_nettype none

// Pixel output stage, sprite line buffer and fix layer into the palette address
module neoB1Top
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire neoB1Pkg::pBusWord_u pBus,	// Sprite X, sprite palette, fix palette
	input wire logic ldX,
	input wire logic ldPal,
	input wire logic pixelWe,
	input wire logic fixPalLd,
	input wire logic fixLd,
	input wire logic [3:0] gColor,	// Sprite pixel colour
	input wire logic [7:0] fixd,	// Fix tile byte
	input wire logic bufFlip,
	input wire logic chbl,
	input wire logic lineStart,
	output wire neoB1Pkg::paWord_t pa
);

	import neoB1Pkg::*;

	sprPix_t sprPix;
	fixPix_t fixPix;

	spriteLineBuffer uSprite
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.pBus(pBus),
		.ldX(ldX),
		.ldPal(ldPal),
		.pixelWe(pixelWe),
		.gColor(gColor),
		.bufFlip(bufFlip),
		.lineStart(lineStart),
		.sprPix(sprPix)
	);

	fixPixelUnit uFix
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.pBus(pBus),
		.fixPalLd(fixPalLd),
		.fixLd(fixLd),
		.fixd(fixd),
		.lineStart(lineStart),
		.fixPix(fixPix)
	);

	// Both pixel paths arrive aligned here
	paletteAddrMux uMux
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.sprPix(sprPix),
		.fixPix(fixPix),
		.chbl(chbl),
		.pa(pa)
	);

endmodule

`default_nettype wire

//--- hdl/paletteAddrMux.sv
`timescale 1ns/10ps
`default_nettype none

// Picks the palette RAM address for each pixel
// Blanking first, then an opaque fix pixel, then sprites
module paletteAddrMux
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire neoB1Pkg::sprPix_t sprPix,
	input wire neoB1Pkg::fixPix_t fixPix,
	input wire logic chbl,
	output neoB1Pkg::paWord_t pa
);

	import neoB1Pkg::*;

	logic fixOpaque;
	logic [paWidth-1:0] nextPa;

	assign fixOpaque = |fixPix.color;

	always_comb
	begin
		if (chbl)
			nextPa = '0;	// Blanking
		else if (fixOpaque)
			nextPa = {4'b0000, fixPix.pal, fixPix.color};	// Fix palettes sit in 0..15
		else
			nextPa = sprPix;	// Sprite or empty slot
	end

	// Palette address register
	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
			pa <= '0;
		else
			pa <= nextPa;
	end

endmodule

`default_nettype wire

//--- lineBuffer/lineBufferRam.sv
`timescale 1ns/10ps
`default_nettype none

// One line bank, 256 slots of palette + colour
// Read is registered, the slot read is cleared behind it
module lineBufferRam
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire logic we,
	input wire logic [7:0] wrAddr,
	input wire neoB1Pkg::sprPix_t wrData,
	input wire logic rdEn,
	input wire logic [7:0] rdAddr,
	output neoB1Pkg::sprPix_t rdData
);

	import neoB1Pkg::*;

	sprPix_t mem [lineWidth];	// Bank storage

	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			// Whole bank starts empty
			for (int i = 0; i < lineWidth; i++)
			begin
				mem[i] <= '0;
			end
			rdData <= '0;
		end
		else
		begin
			if (rdEn)
			begin
				rdData <= mem[rdAddr];	// Old contents go out
				mem[rdAddr] <= '0;	// Clear behind the read
			end
			else
			begin
				rdData <= '0;	// Idle bank shows nothing
			end

			// Last assignment wins, so a write beats the clear
			if (we)
			begin
				mem[wrAddr] <= wrData;
			end
		end
	end

endmodule

`default_nettype wire

//--- lineBuffer/spriteLineBuffer.sv
`timescale 1ns/10ps
`default_nettype none

// Double line buffer for sprite pixels
// One bank fills from the sprite path while the other is read out
module spriteLineBuffer
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire neoB1Pkg::pBusWord_u pBus,
	input wire logic ldX,
	input wire logic ldPal,
	input wire logic pixelWe,
	input wire logic [3:0] gColor,
	input wire logic bufFlip,
	input wire logic lineStart,
	output neoB1Pkg::sprPix_t sprPix
);

	import neoB1Pkg::*;

	logic [7:0] sprPal;	// Sprite palette latch
	logic [7:0] wrAddr;	// Write counter, loaded with sprite X
	logic [7:0] rdCnt;	// Read counter, one slot per pixel
	logic lineActive;	// Readout of a line in progress
	logic flipQ;	// Bank choice one cycle late, matches RAM latency

	logic pixOpaque;
	logic wrEn;
	sprPix_t wrData;
	sprPix_t rdDataA;
	sprPix_t rdDataB;

	// Write side

	assign pixOpaque = |gColor;	// Colour 0 is see-through
	assign wrEn = pixelWe & pixOpaque;
	assign wrData = '{pal: sprPal, color: gColor};

	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			sprPal <= '0;
			wrAddr <= '0;
		end
		else
		begin
			if (ldPal)
				sprPal <= pBus.sprView.sprPal;

			// New sprite start position wins over stepping
			if (ldX)
				wrAddr <= pBus.sprView.sprX;
			else if (pixelWe)
				wrAddr <= wrAddr + 8'd1;	// Steps even for transparent pixels, wraps at 255
		end
	end

	// Read side

	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			rdCnt <= '0;
			lineActive <= 1'b0;
			flipQ <= 1'b0;
		end
		else
		begin
			flipQ <= bufFlip;
			if (lineStart)
			begin
				rdCnt <= '0;	// Restart at slot 0
				lineActive <= 1'b1;
			end
			else
			begin
				rdCnt <= rdCnt + 8'd1;
				// Stop after the last slot so a later flip is not cleared early
				if (lineActive && (rdCnt == 8'(lineWidth - 1)))
					lineActive <= 1'b0;
			end
		end
	end

	// Bank A takes writes when bufFlip is low, bank B when high
	lineBufferRam bankA
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.we(wrEn & ~bufFlip),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn(lineActive & bufFlip),	// Read while B fills
		.rdAddr(rdCnt),
		.rdData(rdDataA)
	);

	lineBufferRam bankB
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.we(wrEn & bufFlip),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn(lineActive & ~bufFlip),	// Read while A fills
		.rdAddr(rdCnt),
		.rdData(rdDataB)
	);

	// Output of the bank that was being read last cycle
	assign sprPix = flipQ ? rdDataA : rdDataB;

endmodule

`default_nettype wire

//--- neoB1.f
common/neoB1Pkg.sv
lineBuffer/lineBufferRam.sv
lineBuffer/spriteLineBuffer.sv
hdl/fixPixelUnit.sv
hdl/paletteAddrMux.sv
hdl/neoB1Top.sv
tb/neoB1_assert.sv
tb/neoB1Tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module neoB1Tb -f neoB1.f -o neoB1Sim \
	&& ./obj_dir/neoB1Sim > sim.log 2>&1 \
	|| echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }

//--- tb/neoB1Tb.sv
`timescale 1ns/10ps
`default_nettype none

// Line tests for the pixel output stage
// Each row writes one sprite and a fix tile byte, then reads the whole line out
module neoB1Tb;

	import neoB1Pkg::*;

	// One row of the stimulus table
	typedef struct packed
	{
		logic [7:0] sprX;
		logic [7:0] sprPal;
		logic [3:0] nColor;	// Listed colours used
		logic [31:0] colors;	// First pixel in the low nibble
		logic [3:0] nRand;	// Random colours after the listed ones
		logic [7:0] fixByte;
		logic [3:0] fixPal;
		logic chbl;
		logic showLine;	// 0 only writes, next row draws on top
		logic [7:0] idx;	// Pixel with a hand-worked value
		logic [11:0] expPa;
	} lineTest_t;

	localparam int numTests = 11;
	localparam int clkPeriodNs = 20;
	localparam int cyclesPerTest = 600;
	localparam int watchdogNs = numTests * cyclesPerTest * clkPeriodNs;

	logic TODO_FIXCLK;
	logic rstN;
	pBusWord_u pBus;
	logic ldX;
	logic ldPal;
	logic pixelWe;
	logic fixPalLd;
	logic fixLd;
	logic [3:0] gColor;
	logic [7:0] fixd;
	logic bufFlip;
	logic chbl;
	logic lineStart;
	paWord_t pa;

	lineTest_t tests [numTests];
	string testNames [numTests];
	sprPix_t bankModel [2][lineWidth];	// Expected contents of both banks
	integer seed;

	neoB1Top DUT
	(
		.TODO_FIXCLK(TODO_FIXCLK),
		.rstN(rstN),
		.pBus(pBus),
		.ldX(ldX),
		.ldPal(ldPal),
		.pixelWe(pixelWe),
		.fixPalLd(fixPalLd),
		.fixLd(fixLd),
		.gColor(gColor),
		.fixd(fixd),
		.bufFlip(bufFlip),
		.chbl(chbl),
		.lineStart(lineStart),
		.pa(pa)
	);

	always
	begin
		#(clkPeriodNs / 2) TODO_FIXCLK = ~TODO_FIXCLK;
	end

	// Inputs change and outputs are read 1 ns after the rising edge
	task automatic stepCycle();
		@(posedge TODO_FIXCLK);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopping on first error");
		end
	endtask

	// Address for pixel n, from blanking, fix opacity and the sprite slot
	function automatic logic [11:0] pixelModel(input sprPix_t spr, input lineTest_t t,
		input int n);
		logic [3:0] fixColor;
		fixColor = (n % 2 == 1) ? t.fixByte[7:4] : t.fixByte[3:0];	// Low nibble on even pixels
		if (t.chbl)
			return '0;
		else if (fixColor != 4'h0)
			return {4'h0, t.fixPal, fixColor};
		else
			return spr;
	endfunction

	task automatic loadTable();
		testNames[0] = "spriteBasic";
		tests[0] = '{sprX: 8'd20, sprPal: 8'h5A, nColor: 4'd4, colors: 32'h4321, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd22, expPa: 12'h5A3};
		testNames[1] = "spriteWrap";
		tests[1] = '{sprX: 8'd254, sprPal: 8'hC3, nColor: 4'd4, colors: 32'h8765, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd0, expPa: 12'hC37};
		testNames[2] = "emptySlot";
		tests[2] = '{sprX: 8'd100, sprPal: 8'h11, nColor: 4'd2, colors: 32'h22, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd150, expPa: 12'h000};
		testNames[3] = "underSprite";
		tests[3] = '{sprX: 8'd40, sprPal: 8'h21, nColor: 4'd4, colors: 32'h5555, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b0, idx: 8'd0, expPa: 12'h000};
		testNames[4] = "transparent";
		tests[4] = '{sprX: 8'd40, sprPal: 8'h33, nColor: 4'd4, colors: 32'h7007, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd41, expPa: 12'h215};
		testNames[5] = "otherBankEmpty";
		tests[5] = '{sprX: 8'd0, sprPal: 8'h00, nColor: 4'd0, colors: 32'h0, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd100, expPa: 12'h000};
		testNames[6] = "rereadCleared";
		tests[6] = '{sprX: 8'd0, sprPal: 8'h00, nColor: 4'd0, colors: 32'h0, nRand: 4'd0,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd41, expPa: 12'h000};
		testNames[7] = "fixOverSprite";
		tests[7] = '{sprX: 8'd10, sprPal: 8'h5A, nColor: 4'd4, colors: 32'h4321, nRand: 4'd0,
			fixByte: 8'h90, fixPal: 4'h3, chbl: 1'b0, showLine: 1'b1, idx: 8'd11, expPa: 12'h039};
		testNames[8] = "fixSeeThrough";
		tests[8] = '{sprX: 8'd10, sprPal: 8'h66, nColor: 4'd4, colors: 32'h4321, nRand: 4'd0,
			fixByte: 8'h0C, fixPal: 4'hE, chbl: 1'b0, showLine: 1'b1, idx: 8'd13, expPa: 12'h664};
		testNames[9] = "blanking";
		tests[9] = '{sprX: 8'd60, sprPal: 8'h77, nColor: 4'd3, colors: 32'h999, nRand: 4'd0,
			fixByte: 8'hFF, fixPal: 4'h1, chbl: 1'b1, showLine: 1'b1, idx: 8'd61, expPa: 12'h000};
		testNames[10] = "spriteRandom";
		tests[10] = '{sprX: 8'd200, sprPal: 8'hA5, nColor: 4'd2, colors: 32'h31, nRand: 4'd6,
			fixByte: 8'h00, fixPal: 4'h0, chbl: 1'b0, showLine: 1'b1, idx: 8'd200, expPa: 12'hA51};
	endtask

	// Sprite into the bank selected by bufFlip, fix latches loaded as well
	task automatic writeSprite(input lineTest_t t);
		logic [7:0] addr;
		logic [3:0] color;
		int total;
		pBus = '0;
		pBus.sprView.sprX = t.sprX;
		pBus.sprView.sprPal = t.sprPal;
		ldX = 1'b1;
		ldPal = 1'b1;
		stepCycle();
		ldX = 1'b0;
		ldPal = 1'b0;
		pBus = '0;
		pBus.fixView.fixPal = t.fixPal;	// Same word, other field
		fixPalLd = 1'b1;
		fixd = t.fixByte;
		fixLd = 1'b1;
		stepCycle();
		fixPalLd = 1'b0;
		fixLd = 1'b0;
		pBus = '0;
		addr = t.sprX;
		total = int'(t.nColor) + int'(t.nRand);
		for (int i = 0; i < total; i++)
		begin
			if (i < int'(t.nColor))
				color = t.colors[i * 4 +: 4];
			else
				color = 4'($random(seed));	// Zero is possible, stays transparent
			gColor = color;
			pixelWe = 1'b1;
			if (color != 4'h0)
				bankModel[bufFlip][addr] = '{pal: t.sprPal, color: color};
			addr = addr + 8'd1;	// Wraps like the write counter
			stepCycle();
		end
		pixelWe = 1'b0;
		gColor = 4'h0;
	endtask

	// Flip banks, start the line and check every pixel of it
	task automatic drawLine(input string name, input lineTest_t t);
		logic readBank;
		sprPix_t spr;
		logic [11:0] expectedPa;
		readBank = bufFlip;	// Bank just written is read next
		bufFlip = ~bufFlip;
		stepCycle();
		lineStart = 1'b1;
		stepCycle();
		lineStart = 1'b0;
		stepCycle();
		for (int n = 0; n < lineWidth; n++)
		begin
			stepCycle();	// Pixel n on pa after edge n+2
			spr = bankModel[readBank][n];
			bankModel[readBank][n] = '0;	// Slot cleared by its read
			expectedPa = pixelModel(spr, t, n);
			if (n == int'(t.idx))
				checkValue(name, t.expPa, pa);
			checkValue($sformatf("%s px%0d", name, n), expectedPa, pa);
		end
		chbl = 1'b0;
	endtask

	initial
	begin
		seed = 44928;
		TODO_FIXCLK = 1'b0;
		rstN = 1'b0;
		pBus = '0;
		ldX = 1'b0;
		ldPal = 1'b0;
		pixelWe = 1'b0;
		fixPalLd = 1'b0;
		fixLd = 1'b0;
		gColor = 4'h0;
		fixd = 8'h00;
		bufFlip = 1'b0;
		chbl = 1'b0;
		lineStart = 1'b0;
		for (int b = 0; b < 2; b++)
		begin
			for (int a = 0; a < lineWidth; a++)
				bankModel[b][a] = '0;
		end
		loadTable();
		repeat (8) @(posedge TODO_FIXCLK);
		#1;
		rstN = 1'b1;
		checkValue("reset", 12'h000, pa);	// Nothing latched yet
		for (int k = 0; k < numTests; k++)
		begin
			chbl = tests[k].chbl;
			writeSprite(tests[k]);
			if (tests[k].showLine)
				drawLine(testNames[k], tests[k]);
		end
		$display("All checks passed");
		$finish;
	end

	// Run length bound from the table size
	initial
	begin
		#(watchdogNs);
		$display("Watchdog expired after %0d ns, the tests did not finish", watchdogNs);
		$display("Checks failed");
		$fatal(1, "Watchdog timeout");
	end

endmodule

`default_nettype wire

//--- tb/neoB1_assert.sv
`timescale 1ns/10ps
`default_nettype none

// Concurrent checks on the pixel output stage
module neoB1Assert
(
	input wire logic TODO_FIXCLK,
	input wire logic rstN,
	input wire logic chbl,
	input wire logic fixLd,
	input wire logic [7:0] fixd,
	input wire logic lineStart,
	input wire neoB1Pkg::fixPix_t fixPix,
	input wire neoB1Pkg::paWord_t pa
);

	logic [7:0] byteSeen;	// Mirror of the tile byte latch
	logic evenPix;	// High on even pixels

	always_ff @(posedge TODO_FIXCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			byteSeen <= '0;
			evenPix <= 1'b1;
		end
		else
		begin
			if (fixLd)
				byteSeen <= fixd;
			evenPix <= lineStart ? 1'b1 : ~evenPix;	// Line start restarts at pixel 0
		end
	end

	blankZero: assert property (@(posedge TODO_FIXCLK) disable iff (!rstN)
		chbl |=> (pa == '0))
		else $error("pa not zero one cycle after chbl");

	// Address held at zero through reset
	resetZero: assert property (@(posedge TODO_FIXCLK) !rstN |-> (pa == '0))
		else $error("pa not zero during reset");

	fixLowNibble: assert property (@(posedge TODO_FIXCLK) disable iff (!rstN)
		evenPix |=> (fixPix.color == $past(byteSeen[3:0])))
		else $error("fix colour is not the low nibble on an even pixel");

endmodule

bind neoB1Top neoB1Assert uAssert
(
	.TODO_FIXCLK(TODO_FIXCLK),
	.rstN(rstN),
	.chbl(chbl),
	.fixLd(fixLd),
	.fixd(fixd),
	.lineStart(lineStart),
	.fixPix(fixPix),
	.pa(pa)
);

`default_nettype wire
